//--- logic/msg_pkg.sv
// Message link types, field positions and decode functions
// shared by the arbiter, the router and the top level

package msg_pkg;

    // *******************************************************************
    // Link widths
    // *******************************************************************

    // One single-beat link message
    typedef logic [63:0] msg_t;

    // Register address carried by a request
    typedef logic [19:0] addr_t;

    // Endpoint index
    typedef logic [1:0]  dest_t;

    // Number of endpoints served by the arbiter
    localparam int NUM_EP = 4;

    // *******************************************************************
    // Field positions
    // *******************************************************************

    // Set in a read response
    localparam int MSG_RESP_BIT = 63;

    // Set in a read request, clear in a write
    localparam int MSG_RD_BIT   = 62;

    // Lowest bit of the address field, data sits in bits 31 to 0
    localparam int MSG_ADDR_LSB = 32;

    // *******************************************************************
    // Decode functions
    // *******************************************************************

    // Response flag of a message
    function automatic logic msg_is_response(input msg_t msg);
        return msg[MSG_RESP_BIT];
    endfunction

    // True for a read request, never for a response
    function automatic logic msg_is_rd_request(input msg_t msg);
        return msg[MSG_RD_BIT] && !msg[MSG_RESP_BIT];
    endfunction

    // Register address of a request
    function automatic addr_t msg_address(input msg_t msg);
        return msg[MSG_ADDR_LSB +: $bits(addr_t)];
    endfunction

endpackage

//--- logic/msg_upstream_arbiter.sv
// Round-robin 4-to-1 merge of endpoint messages onto the host link,
// with capture of the endpoint that sent the last read request
`timescale 1ns/100ps

module msg_upstream_arbiter (
    input  logic                                        clk,
    input  logic                                        reset,

    // Endpoint side
    input  msg_pkg::msg_t [msg_pkg::NUM_EP-1:0]         ep_data,
    input  logic          [msg_pkg::NUM_EP-1:0]         ep_valid,
    output logic          [msg_pkg::NUM_EP-1:0]         ep_ready,

    // Host side
    output msg_pkg::msg_t                               host_data,
    output logic                                        host_valid,
    input  logic                                        host_ready,

    // Read request tracking for the router
    output logic                                        rd_seen,
    output msg_pkg::dest_t                              rd_dest
);

    import msg_pkg::*;

    // Round-robin pointer, first endpoint to be looked at
    dest_t ptr;

    // Arbitration result
    dest_t grant;
    logic  found;
    logic  xfer;

    // *******************************************************************
    // Grant selection
    // *******************************************************************

    // First valid endpoint at or after the pointer, wrapping at NUM_EP
    always_comb begin
        dest_t cand;
        grant = ptr;
        found = 1'b0;
        for (int i = 0; i < NUM_EP; i++) begin
            cand = dest_t'(ptr + dest_t'(i));
            if (!found && ep_valid[cand]) begin
                grant = cand;
                found = 1'b1;
            end
        end
    end

    assign xfer = host_valid && host_ready;

    // *******************************************************************
    // Data path and handshake
    // *******************************************************************

    assign host_data  = ep_data[grant];
    assign host_valid = found;

    // Only the granted endpoint sees the host ready
    always_comb begin
        ep_ready        = '0;
        ep_ready[grant] = host_ready && found;
    end

    // Accepted read request and its source
    assign rd_seen = xfer && msg_is_rd_request(host_data);
    assign rd_dest = grant;

    // *******************************************************************
    // Pointer
    // *******************************************************************

    // Moves only on a transfer so a stalled grant stays in place
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (xfer) begin
            // Next search starts one above the endpoint just served
            ptr <= dest_t'(grant + dest_t'(1));
        end
    end

endmodule

//--- logic/msg_downstream_router.sv
// Address decode and 1-to-4 routing of host messages, with read
// responses returned to the endpoint of the last accepted read
`timescale 1ns/100ps

module msg_downstream_router #(
    parameter msg_pkg::addr_t E0_ADDR = 20'h0,
    parameter msg_pkg::addr_t E0_MASK = 20'h0,
    parameter msg_pkg::addr_t E1_ADDR = 20'h0,
    parameter msg_pkg::addr_t E1_MASK = 20'h0,
    parameter msg_pkg::addr_t E2_ADDR = 20'h0,
    parameter msg_pkg::addr_t E2_MASK = 20'h0,
    parameter msg_pkg::addr_t E3_ADDR = 20'h0,
    parameter msg_pkg::addr_t E3_MASK = 20'h0
) (
    input  logic                                        clk,
    input  logic                                        reset,

    // Host side
    input  msg_pkg::msg_t                               host_data,
    input  logic                                        host_valid,
    output logic                                        host_ready,

    // Endpoint side
    output msg_pkg::msg_t [msg_pkg::NUM_EP-1:0]         ep_data,
    output logic          [msg_pkg::NUM_EP-1:0]         ep_valid,
    input  logic          [msg_pkg::NUM_EP-1:0]         ep_ready,

    // Last read request seen upstream
    input  logic                                        rd_seen,
    input  msg_pkg::dest_t                              rd_dest
);

    import msg_pkg::*;

    // Address windows, entry n belongs to endpoint n
    localparam addr_t [NUM_EP-1:0] EP_ADDR = {E3_ADDR, E2_ADDR, E1_ADDR, E0_ADDR};
    localparam addr_t [NUM_EP-1:0] EP_MASK = {E3_MASK, E2_MASK, E1_MASK, E0_MASK};

    addr_t req_addr;
    logic  is_resp;

    // Destination of a request and of a response
    dest_t req_dest;
    dest_t resp_dest;
    dest_t dest;

    // *******************************************************************
    // Destination decode
    // *******************************************************************

    assign req_addr = msg_address(host_data);
    assign is_resp  = msg_is_response(host_data);

    // Scan from the top so the lowest matching endpoint wins,
    // unmatched addresses fall back to endpoint 0
    always_comb begin
        req_dest = '0;
        for (int i = NUM_EP - 1; i >= 0; i--) begin
            if ((req_addr & EP_MASK[i]) == EP_ADDR[i]) begin
                req_dest = dest_t'(i);
            end
        end
    end

    // Responses follow the last read, requests follow the address
    assign dest = is_resp ? resp_dest : req_dest;

    // Response destination, updated at the edge after a read is accepted
    always_ff @(posedge clk) begin
        if (reset) begin
            resp_dest <= '0;
        end else if (rd_seen) begin
            resp_dest <= rd_dest;
        end
    end

    // *******************************************************************
    // Routing
    // *******************************************************************

    // Every endpoint sees the message, valid marks the owner
    always_comb begin
        for (int i = 0; i < NUM_EP; i++) begin
            ep_data[i] = host_data;
        end
    end

    always_comb begin
        ep_valid       = '0;
        ep_valid[dest] = host_valid;
    end

    assign host_ready = ep_ready[dest];

endmodule

//--- logic/msg_arbiter.sv
// Top level of the host message arbiter for four endpoints,
// upstream round-robin merge beside downstream address routing
`timescale 1ns/100ps

module msg_arbiter #(
    parameter msg_pkg::addr_t E0_ADDR = 20'h0,
    parameter msg_pkg::addr_t E0_MASK = 20'h0,
    parameter msg_pkg::addr_t E1_ADDR = 20'h0,
    parameter msg_pkg::addr_t E1_MASK = 20'h0,
    parameter msg_pkg::addr_t E2_ADDR = 20'h0,
    parameter msg_pkg::addr_t E2_MASK = 20'h0,
    parameter msg_pkg::addr_t E3_ADDR = 20'h0,
    parameter msg_pkg::addr_t E3_MASK = 20'h0
) (
    input  logic            clk,
    input  logic            reset,

    // Host link
    input  msg_pkg::msg_t   regi_data,
    input  logic            regi_valid,
    output logic            regi_ready,
    output msg_pkg::msg_t   rego_data,
    output logic            rego_valid,
    input  logic            rego_ready,

    // Endpoint 0
    output msg_pkg::msg_t   e0_regi_data,
    output logic            e0_regi_valid,
    input  logic            e0_regi_ready,
    input  msg_pkg::msg_t   e0_rego_data,
    input  logic            e0_rego_valid,
    output logic            e0_rego_ready,

    // Endpoint 1
    output msg_pkg::msg_t   e1_regi_data,
    output logic            e1_regi_valid,
    input  logic            e1_regi_ready,
    input  msg_pkg::msg_t   e1_rego_data,
    input  logic            e1_rego_valid,
    output logic            e1_rego_ready,

    // Endpoint 2
    output msg_pkg::msg_t   e2_regi_data,
    output logic            e2_regi_valid,
    input  logic            e2_regi_ready,
    input  msg_pkg::msg_t   e2_rego_data,
    input  logic            e2_rego_valid,
    output logic            e2_rego_ready,

    // Endpoint 3
    output msg_pkg::msg_t   e3_regi_data,
    output logic            e3_regi_valid,
    input  logic            e3_regi_ready,
    input  msg_pkg::msg_t   e3_rego_data,
    input  logic            e3_rego_valid,
    output logic            e3_rego_ready
);

    import msg_pkg::*;

    // *******************************************************************
    // Endpoint ports gathered into arrays
    // *******************************************************************

    msg_t [NUM_EP-1:0] up_data;
    logic [NUM_EP-1:0] up_valid;
    logic [NUM_EP-1:0] up_ready;
    msg_t [NUM_EP-1:0] dn_data;
    logic [NUM_EP-1:0] dn_valid;
    logic [NUM_EP-1:0] dn_ready;

    // Last read request, arbiter to router
    logic  rd_seen;
    dest_t rd_dest;

    assign up_data  = {e3_rego_data, e2_rego_data, e1_rego_data, e0_rego_data};
    assign up_valid = {e3_rego_valid, e2_rego_valid, e1_rego_valid, e0_rego_valid};
    assign {e3_rego_ready, e2_rego_ready, e1_rego_ready, e0_rego_ready} = up_ready;

    assign {e3_regi_data, e2_regi_data, e1_regi_data, e0_regi_data} = dn_data;
    assign {e3_regi_valid, e2_regi_valid, e1_regi_valid, e0_regi_valid} = dn_valid;
    assign dn_ready = {e3_regi_ready, e2_regi_ready, e1_regi_ready, e0_regi_ready};

    // *******************************************************************
    // Upstream merge and downstream routing
    // *******************************************************************

    msg_upstream_arbiter upstream (
        .clk(clk), .reset(reset),
        .ep_data(up_data), .ep_valid(up_valid), .ep_ready(up_ready),
        .host_data(rego_data), .host_valid(rego_valid), .host_ready(rego_ready),
        .rd_seen(rd_seen), .rd_dest(rd_dest)
    );

    msg_downstream_router #(
        .E0_ADDR(E0_ADDR), .E0_MASK(E0_MASK),
        .E1_ADDR(E1_ADDR), .E1_MASK(E1_MASK),
        .E2_ADDR(E2_ADDR), .E2_MASK(E2_MASK),
        .E3_ADDR(E3_ADDR), .E3_MASK(E3_MASK)
    ) downstream (
        .clk(clk), .reset(reset),
        .host_data(regi_data), .host_valid(regi_valid), .host_ready(regi_ready),
        .ep_data(dn_data), .ep_valid(dn_valid), .ep_ready(dn_ready),
        .rd_seen(rd_seen), .rd_dest(rd_dest)
    );

endmodule

//--- verification/msg_arbiter_asserts.sv
// Handshake checks on the host and endpoint outputs of the arbiter top level,
// bound into every instance of the top level
`timescale 1ns/100ps

module msg_arbiter_asserts (
    input  logic                                    clk,
    input  logic                                    reset,
    input  msg_pkg::msg_t                           rego_data,
    input  logic                                    rego_valid,
    input  logic                                    rego_ready,
    input  msg_pkg::msg_t [msg_pkg::NUM_EP-1:0]     dn_data,
    input  logic          [msg_pkg::NUM_EP-1:0]     dn_valid,
    input  logic          [msg_pkg::NUM_EP-1:0]     dn_ready
);

    import msg_pkg::*;

    // Count of failed assertions
    int fail_count = 0;

    // Endpoints holding a message that was not taken
    logic [NUM_EP-1:0] stalled;

    assign stalled = dn_valid & ~dn_ready;

    host_hold: assert property (@(posedge clk) disable iff (reset)
        rego_valid && !rego_ready |=> rego_valid && $stable(rego_data))
    else begin
        fail_count++;
        $error("host message dropped or changed while the host held ready low");
    end

    ep_hold: assert property (@(posedge clk) disable iff (reset)
        stalled != '0 |=> (dn_valid & $past(stalled)) == $past(stalled) && $stable(dn_data))
    else begin
        fail_count++;
        $error("endpoint message dropped or changed while the endpoint held ready low");
    end

    one_endpoint: assert property (@(posedge clk) disable iff (reset)
        $onehot0(dn_valid))
    else begin
        fail_count++;
        $error("more than one endpoint valid at the same time");
    end

endmodule

bind msg_arbiter msg_arbiter_asserts checks (
    .clk(clk),
    .reset(reset),
    .rego_data(rego_data),
    .rego_valid(rego_valid),
    .rego_ready(rego_ready),
    .dn_data(dn_data),
    .dn_valid(dn_valid),
    .dn_ready(dn_ready)
);

//--- verification/msg_arbiter_tb.sv
// Testbench for the message arbiter with clock, reset, host and endpoint models,
// reference state, checking assertions and the test sequence
`timescale 1ns/100ps

module msg_arbiter_tb;

    import msg_pkg::*;

    // Ten times the expected run length
    localparam int MAX_CYCLES = 2000;

    // Endpoint address windows, entry n belongs to endpoint n
    localparam addr_t [3:0] WIN_ADDR = {20'h21000, 20'h20000, 20'h10000, 20'h00000};
    localparam addr_t [3:0] WIN_MASK = {20'hFF000, 20'hFF000, 20'hF0000, 20'hF0000};

    // Window corners and addresses outside every window
    localparam addr_t CORNERS [6] = '{20'h01234, 20'h1ABCD, 20'h20FFF,
                                      20'h21000, 20'h22000, 20'hF0000};

    logic       clk;
    logic       reset;
    msg_t       regi_data;
    logic       regi_valid;
    logic       regi_ready;
    msg_t       rego_data;
    logic       rego_valid;
    logic       rego_ready;
    msg_t [3:0] dn_data;
    logic [3:0] dn_valid;
    logic [3:0] dn_ready;
    msg_t [3:0] up_data;
    logic [3:0] up_valid;
    logic [3:0] up_ready;

    // Reference state, follows the accepted transfers
    dest_t      exp_ptr;
    dest_t      exp_resp_dest;
    dest_t      exp_grant;
    dest_t      exp_dest;
    logic [3:0] want_dn_valid;
    logic [3:0] want_up_ready;
    logic       want_regi_ready;
    msg_t       routed_data;
    msg_t       granted_data;

    int errors = 0;
    int checks_at_start = 0;
    int tests_run = 0;
    int cycles = 0;

    msg_arbiter #(
        .E0_ADDR(WIN_ADDR[0]), .E0_MASK(WIN_MASK[0]),
        .E1_ADDR(WIN_ADDR[1]), .E1_MASK(WIN_MASK[1]),
        .E2_ADDR(WIN_ADDR[2]), .E2_MASK(WIN_MASK[2]),
        .E3_ADDR(WIN_ADDR[3]), .E3_MASK(WIN_MASK[3])
    ) UUT (
        .clk(clk), .reset(reset),
        .regi_data(regi_data), .regi_valid(regi_valid), .regi_ready(regi_ready),
        .rego_data(rego_data), .rego_valid(rego_valid), .rego_ready(rego_ready),
        .e0_regi_data(dn_data[0]), .e0_regi_valid(dn_valid[0]), .e0_regi_ready(dn_ready[0]),
        .e0_rego_data(up_data[0]), .e0_rego_valid(up_valid[0]), .e0_rego_ready(up_ready[0]),
        .e1_regi_data(dn_data[1]), .e1_regi_valid(dn_valid[1]), .e1_regi_ready(dn_ready[1]),
        .e1_rego_data(up_data[1]), .e1_rego_valid(up_valid[1]), .e1_rego_ready(up_ready[1]),
        .e2_regi_data(dn_data[2]), .e2_regi_valid(dn_valid[2]), .e2_regi_ready(dn_ready[2]),
        .e2_rego_data(up_data[2]), .e2_rego_valid(up_valid[2]), .e2_rego_ready(up_ready[2]),
        .e3_regi_data(dn_data[3]), .e3_regi_valid(dn_valid[3]), .e3_regi_ready(dn_ready[3]),
        .e3_rego_data(up_data[3]), .e3_rego_valid(up_valid[3]), .e3_rego_ready(up_ready[3])
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // *******************************************************************
    // Reference model
    // *******************************************************************

    // First window that matches wins, endpoint 0 otherwise
    function automatic dest_t route_for(input addr_t addr);
        dest_t dest;
        logic  hit;
        dest = 2'd0;
        hit  = 1'b0;
        for (int n = 0; n < 4; n++) begin
            if (!hit && (addr & WIN_MASK[n]) == WIN_ADDR[n]) begin
                dest = dest_t'(n);
                hit  = 1'b1;
            end
        end
        return dest;
    endfunction

    // Rotate the valid bits down to the start index and take the lowest one
    function automatic dest_t rr_pick(input dest_t start, input logic [3:0] valid);
        logic [7:0] twice;
        logic [3:0] rot;
        dest_t      offset;
        twice  = {valid, valid} >> start;
        rot    = twice[3:0];
        offset = rot[0] ? 2'd0 : rot[1] ? 2'd1 : rot[2] ? 2'd2 : 2'd3;
        return start + offset;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            exp_ptr       <= '0;
            exp_resp_dest <= '0;
        end else if (rego_ready && up_valid != 4'h0) begin
            exp_ptr <= exp_grant + 2'd1;
            if (granted_data[MSG_RD_BIT] && !granted_data[MSG_RESP_BIT]) begin
                exp_resp_dest <= exp_grant;
            end
        end
    end

    assign exp_grant       = rr_pick(exp_ptr, up_valid);
    assign exp_dest        = regi_data[MSG_RESP_BIT] ? exp_resp_dest
                                                     : route_for(regi_data[MSG_ADDR_LSB +: 20]);
    assign want_dn_valid   = regi_valid ? 4'b0001 << exp_dest : 4'h0;
    assign want_up_ready   = (rego_ready && up_valid != 4'h0) ? 4'b0001 << exp_grant : 4'h0;
    assign want_regi_ready = dn_ready[exp_dest];
    assign routed_data     = dn_data[exp_dest];
    assign granted_data    = up_data[exp_grant];

    // *******************************************************************
    // Checks
    // *******************************************************************

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("FAILED %s: expected %h, got %h", name, expected, actual);
    endtask

    dn_valid_check: assert property (@(posedge clk) disable iff (reset)
        dn_valid == want_dn_valid)
        else report_mismatch("e3..e0_regi_valid", 64'($sampled(want_dn_valid)),
                             64'($sampled(dn_valid)));

    dn_data_check: assert property (@(posedge clk) disable iff (reset)
        regi_valid |-> routed_data == regi_data)
        else report_mismatch("en_regi_data", $sampled(regi_data), $sampled(routed_data));

    regi_ready_check: assert property (@(posedge clk) disable iff (reset)
        regi_valid |-> regi_ready == want_regi_ready)
        else report_mismatch("regi_ready", 64'($sampled(want_regi_ready)),
                             64'($sampled(regi_ready)));

    rego_valid_check: assert property (@(posedge clk) disable iff (reset)
        rego_valid == (up_valid != 4'h0))
        else report_mismatch("rego_valid", 64'($sampled(up_valid) != 4'h0),
                             64'($sampled(rego_valid)));

    rego_data_check: assert property (@(posedge clk) disable iff (reset)
        rego_valid |-> rego_data == granted_data)
        else report_mismatch("rego_data", $sampled(granted_data), $sampled(rego_data));

    up_ready_check: assert property (@(posedge clk) disable iff (reset)
        up_ready == want_up_ready)
        else report_mismatch("e3..e0_rego_ready", 64'($sampled(want_up_ready)),
                             64'($sampled(up_ready)));

    // *******************************************************************
    // Host and endpoint models
    // *******************************************************************

    function automatic addr_t random_addr();
        return {4'($urandom_range(2, 0)), 16'($urandom)};
    endfunction

    function automatic msg_t make_msg(input logic resp, input logic rd, input addr_t addr);
        return {resp, rd, 10'h000, addr, 32'($urandom)};
    endfunction

    function automatic int failed_checks();
        return errors + UUT.checks.fail_count;
    endfunction

    // Host sends one message, endpoints take it when ready
    task automatic send_down(input msg_t msg, input logic random_ready);
        logic took;
        took = 1'b0;
        while (!took) begin
            @(negedge clk);
            regi_data  = msg;
            regi_valid = 1'b1;
            dn_ready   = random_ready ? 4'($urandom) : 4'hF;
            #1;
            took = regi_ready;
        end
        @(negedge clk);
        regi_valid = 1'b0;
    endtask

    // Loaded endpoints each send per_ep messages to the host
    task automatic run_upstream(input logic [3:0] load, input int per_ep, input logic rd,
                                input logic stall);
        int         left [4];
        logic [3:0] took;
        @(negedge clk);
        for (int n = 0; n < 4; n++) begin
            left[n]    = load[n] ? per_ep : 0;
            up_data[n] = make_msg(1'b0, rd, random_addr());
        end
        up_valid = load;
        while (up_valid != 4'h0) begin
            rego_ready = stall ? 1'($urandom) : 1'b1;
            #1;
            took = up_valid & up_ready;
            @(negedge clk);
            for (int n = 0; n < 4; n++) begin
                if (took[n]) begin
                    left[n]--;
                    up_data[n]  = make_msg(1'b0, rd, random_addr());
                    up_valid[n] = (left[n] > 0);
                end
            end
        end
        rego_ready = 1'b1;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        $display("test %0d, %s: %0d failed checks", tests_run, name,
                 failed_checks() - checks_at_start);
        checks_at_start = failed_checks();
    endtask

    // *******************************************************************
    // Test sequence
    // *******************************************************************

    initial begin
        void'($urandom(32'h3144));
        reset      = 1'b1;
        regi_data  = '0;
        regi_valid = 1'b0;
        rego_ready = 1'b1;
        dn_ready   = 4'hF;
        up_data    = '0;
        up_valid   = 4'h0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Response before any read, then endpoints 2 and 3 compete
        send_down(make_msg(1'b1, 1'b0, random_addr()), 1'b0);
        run_upstream(4'b1100, 1, 1'b0, 1'b0);
        close_test("reset state");

        for (int i = 0; i < 6; i++) begin
            send_down(make_msg(1'b0, 1'(i), CORNERS[i]), 1'b0);
        end
        repeat (8) begin
            send_down(make_msg(1'b0, 1'($urandom), random_addr()), 1'b0);
        end
        close_test("request routing");

        run_upstream(4'hF, 2, 1'b0, 1'b0);
        close_test("round-robin merge");

        // Each new reader takes over the responses
        for (int k = 3; k >= 0; k--) begin
            run_upstream(4'b0001 << k, 1, 1'b1, 1'b0);
            send_down(make_msg(1'b1, 1'b0, random_addr()), 1'b0);
            send_down(make_msg(1'b1, 1'b0, random_addr()), 1'b0);
        end
        close_test("response return");

        repeat (6) begin
            send_down(make_msg(1'b0, 1'($urandom), random_addr()), 1'b1);
        end
        run_upstream(4'hF, 2, 1'b1, 1'b1);
        send_down(make_msg(1'b1, 1'b0, random_addr()), 1'b1);
        close_test("back-pressure");

        $display("%0d tests done, %0d failed checks", tests_run, failed_checks());
        if (failed_checks() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: test sequence still running after %0d cycles", MAX_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- sim.f
logic/msg_pkg.sv
logic/msg_upstream_arbiter.sv
logic/msg_downstream_router.sv
logic/msg_arbiter.sv
verification/msg_arbiter_asserts.sv
verification/msg_arbiter_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the message arbiter testbench with Verilator, run it and
# look for the fail message in the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module msg_arbiter_tb -f sim.f \
    -o msg_arbiter_sim

if ! ./obj_dir/msg_arbiter_sim +verilator+error+limit+1000 > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
